// ==== common/brat_pkg.sv ====
package brat_pkg;

    // ========================================
    // Sizes
    // ========================================

    // Data and PC width
    localparam int XLEN = 32;

    // Execute lanes that report branch outcomes
    localparam int NUM_LANES = 3;

    // Branch resolution table
    localparam int BRAT_DEPTH = 8;
    localparam int BRAT_ID_W  = 3;

    // Global history and pattern table
    localparam int HIST_W      = 6;
    localparam int PHT_ENTRIES = 64;
    localparam int PHT_INDEX_W = 6;

    // Weakly not-taken
    localparam logic [1:0] CTR_INIT = 2'b01;

    // ========================================
    // Types
    // ========================================

    typedef logic [XLEN-1:0]      pc_t;
    typedef logic [BRAT_ID_W-1:0] brat_id_t;
    typedef logic [HIST_W-1:0]    ghist_t;

    // One predicted branch from the front end, in program order
    typedef struct packed {
        logic valid;
        pc_t  pc;
        logic predicted_taken;
    } alloc_req_t;

    // Outcome strobe from one execute lane
    typedef struct packed {
        logic     valid;
        brat_id_t id;
        logic     mispredicted;
        logic     taken;
        pc_t      correct_pc;
    } exec_result_t;

    // In-order release of the oldest resolved branch
    typedef struct packed {
        logic   valid;
        logic   mispredicted;
        logic   taken;
        pc_t    pc;
        pc_t    correct_pc;
        ghist_t history;
    } retire_t;

endpackage

// ==== brat/brat_table.sv ====
`timescale 1ns/1ns

module brat_table (
    input  logic                                             clk,
    input  logic                                             reset_i,
    input  brat_pkg::alloc_req_t                             alloc_i,
    input  brat_pkg::ghist_t                                 alloc_hist_i,
    input  brat_pkg::exec_result_t [brat_pkg::NUM_LANES-1:0] exec_i,
    output brat_pkg::brat_id_t                               alloc_id_o,
    output logic                                             brat_full_o,
    output brat_pkg::retire_t                                retire_o,
    output logic                                             redirect_o,
    output brat_pkg::pc_t                                    redirect_pc_o
);

    // Tail is the next index handed out
    brat_pkg::brat_id_t head_q;
    brat_pkg::brat_id_t tail_q;
    logic [brat_pkg::BRAT_ID_W:0] count_q;

    // Per-entry state flags
    logic [brat_pkg::BRAT_DEPTH-1:0] busy_q;
    logic [brat_pkg::BRAT_DEPTH-1:0] resolved_q;

    // Entry payload written at allocation
    brat_pkg::pc_t    pc_mem   [brat_pkg::BRAT_DEPTH];
    brat_pkg::ghist_t hist_mem [brat_pkg::BRAT_DEPTH];

    // Entry payload written by the lanes
    brat_pkg::pc_t                   cpc_mem [brat_pkg::BRAT_DEPTH];
    logic [brat_pkg::BRAT_DEPTH-1:0] mispred_mem;
    logic [brat_pkg::BRAT_DEPTH-1:0] taken_mem;

    logic              alloc_en;
    logic              release_en;
    logic              flush;
    brat_pkg::retire_t retire_q;

    assign brat_full_o = (count_q == brat_pkg::BRAT_DEPTH);
    assign alloc_en    = alloc_i.valid && !brat_full_o;

    // Resolved flags only ever sit on busy entries
    assign release_en = resolved_q[head_q];
    assign flush      = release_en && mispred_mem[head_q];

    // ========================================
    // Pointers and flags
    // ========================================

    always_ff @(posedge clk) begin
        if (reset_i || flush) begin
            // Mispredicted head drops every younger entry and any new allocation
            head_q     <= '0;
            tail_q     <= '0;
            count_q    <= '0;
            busy_q     <= '0;
            resolved_q <= '0;
        end else begin
            if (alloc_en) begin
                tail_q             <= tail_q + 1'b1;
                busy_q[tail_q]     <= 1'b1;
                resolved_q[tail_q] <= 1'b0;
            end

            if (release_en) begin
                head_q             <= head_q + 1'b1;
                busy_q[head_q]     <= 1'b0;
                resolved_q[head_q] <= 1'b0;
            end

            // Lanes mark distinct entries in any order
            for (int l = 0; l < brat_pkg::NUM_LANES; l++) begin
                if (exec_i[l].valid && busy_q[exec_i[l].id]) begin
                    resolved_q[exec_i[l].id] <= 1'b1;
                end
            end

            if (alloc_en && !release_en) begin
                count_q <= count_q + 1'b1;
            end else if (!alloc_en && release_en) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // ========================================
    // Entry storage
    // ========================================

    always_ff @(posedge clk) begin
        if (alloc_en) begin
            pc_mem[tail_q]   <= alloc_i.pc;
            hist_mem[tail_q] <= alloc_hist_i;
        end

        for (int l = 0; l < brat_pkg::NUM_LANES; l++) begin
            if (exec_i[l].valid) begin
                mispred_mem[exec_i[l].id] <= exec_i[l].mispredicted;
                taken_mem[exec_i[l].id]   <= exec_i[l].taken;
                cpc_mem[exec_i[l].id]     <= exec_i[l].correct_pc;
            end
        end
    end

    // ========================================
    // In-order release register
    // ========================================

    always_ff @(posedge clk) begin
        if (reset_i) begin
            retire_q.valid <= 1'b0;
        end else begin
            retire_q.valid <= release_en;
            if (release_en) begin
                retire_q.mispredicted <= mispred_mem[head_q];
                retire_q.taken        <= taken_mem[head_q];
                retire_q.pc           <= pc_mem[head_q];
                retire_q.correct_pc   <= cpc_mem[head_q];
                retire_q.history      <= hist_mem[head_q];
            end
        end
    end

    assign retire_o      = retire_q;
    assign alloc_id_o    = tail_q;

    // Redirect rides on the release that emptied the table
    assign redirect_o    = retire_q.valid && retire_q.mispredicted;
    assign redirect_pc_o = retire_q.correct_pc;

    // ========================================
    // Checks
    // ========================================

    // Front end must hold allocations while full
    a_alloc_not_full: assert property (@(posedge clk) disable iff (reset_i)
        alloc_i.valid |-> !brat_full_o)
        else $error("allocation while branch table is full");

    // A lane may only resolve an allocated entry
    for (genvar g = 0; g < brat_pkg::NUM_LANES; g++) begin : g_lane_chk
        a_strobe_busy: assert property (@(posedge clk) disable iff (reset_i)
            exec_i[g].valid |-> busy_q[exec_i[g].id])
            else $error("lane %0d resolved an entry that is not allocated", g);
    end

    // Nothing leaves the table on the first cycle out of reset
    a_quiet_after_reset: assert property (@(posedge clk)
        $fell(reset_i) |=> (!retire_o.valid && !redirect_o))
        else $error("release or redirect right after reset");

endmodule

// ==== logic/gshare_predictor.sv ====
`timescale 1ns/1ns

module gshare_predictor (
    input  logic                 clk,
    input  logic                 reset_i,
    input  brat_pkg::pc_t        predict_pc_i,
    output logic                 predict_taken_o,
    input  brat_pkg::alloc_req_t alloc_i,
    output brat_pkg::ghist_t     history_o,
    input  brat_pkg::retire_t    retire_i
);

    // 2-bit saturating counters
    logic [1:0] pht_q [brat_pkg::PHT_ENTRIES];

    // Speculative global history
    brat_pkg::ghist_t ghist_q;

    logic [brat_pkg::PHT_INDEX_W-1:0] lookup_idx;
    logic [brat_pkg::PHT_INDEX_W-1:0] train_idx;
    logic                             shift_en;
    logic                             repair_en;

    // Word PC bits folded with the history
    function automatic logic [brat_pkg::PHT_INDEX_W-1:0] pht_index(
        input brat_pkg::pc_t    pc,
        input brat_pkg::ghist_t hist
    );
        return pc[brat_pkg::PHT_INDEX_W+1:2] ^ hist;
    endfunction

    // ========================================
    // Lookup
    // ========================================

    assign lookup_idx      = pht_index(predict_pc_i, ghist_q);
    assign predict_taken_o = pht_q[lookup_idx][1];
    assign history_o       = ghist_q;

    // ========================================
    // History
    // ========================================

    assign shift_en  = alloc_i.valid && alloc_i.predicted_taken;
    assign repair_en = retire_i.valid && retire_i.mispredicted;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ghist_q <= '0;
        end else if (repair_en) begin
            // Back to the history seen by the branch, plus its real outcome
            ghist_q <= {retire_i.history[brat_pkg::HIST_W-2:0], retire_i.taken};
        end else if (shift_en) begin
            ghist_q <= {ghist_q[brat_pkg::HIST_W-2:0], alloc_i.predicted_taken};
        end
    end

    // ========================================
    // Training
    // ========================================

    // Index comes from the state stored with the branch, not the live history
    assign train_idx = pht_index(retire_i.pc, retire_i.history);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < brat_pkg::PHT_ENTRIES; i++) begin
                pht_q[i] <= brat_pkg::CTR_INIT;
            end
        end else if (retire_i.valid) begin
            if (retire_i.taken && (pht_q[train_idx] != 2'b11)) begin
                pht_q[train_idx] <= pht_q[train_idx] + 2'd1;
            end else if (!retire_i.taken && (pht_q[train_idx] != 2'b00)) begin
                pht_q[train_idx] <= pht_q[train_idx] - 2'd1;
            end
        end
    end

    // Front end is flushed while a repair lands, so no speculative shift then
    a_no_shift_on_repair: assert property (@(posedge clk) disable iff (reset_i)
        repair_en |-> !shift_en)
        else $error("history shift during a history repair");

endmodule

// ==== logic/branch_resolution_top.sv ====
`timescale 1ns/1ns

module branch_resolution_top (
    input  logic                                             clk,
    input  logic                                             reset_i,
    input  brat_pkg::alloc_req_t                             alloc_i,
    output brat_pkg::brat_id_t                               alloc_id_o,
    output logic                                             brat_full_o,
    input  brat_pkg::pc_t                                    predict_pc_i,
    output logic                                             predict_taken_o,
    input  brat_pkg::exec_result_t [brat_pkg::NUM_LANES-1:0] exec_i,
    output brat_pkg::retire_t                                retire_o,
    output logic                                             redirect_o,
    output brat_pkg::pc_t                                    redirect_pc_o
);

    // Speculative history captured into each new entry
    brat_pkg::ghist_t spec_hist;

    // Release stream, also trains the predictor
    brat_pkg::retire_t retire;

    // ========================================
    // Branch resolution table
    // ========================================

    brat_table i_brat_table (
        .clk           (clk),
        .reset_i       (reset_i),
        .alloc_i       (alloc_i),
        .alloc_hist_i  (spec_hist),
        .exec_i        (exec_i),
        .alloc_id_o    (alloc_id_o),
        .brat_full_o   (brat_full_o),
        .retire_o      (retire),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o)
    );

    // ========================================
    // Predictor
    // ========================================

    gshare_predictor i_gshare_predictor (
        .clk             (clk),
        .reset_i         (reset_i),
        .predict_pc_i    (predict_pc_i),
        .predict_taken_o (predict_taken_o),
        .alloc_i         (alloc_i),
        .history_o       (spec_hist),
        .retire_i        (retire)
    );

    assign retire_o = retire;

endmodule

// ==== tests/tb_vectors.svh ====
// Columns: allocation, lane 0, lane 1, lane 2, random lookup, lookup pc,
// expected brat_full_o, expected alloc_id_o, expected release

// Idle after reset with random lookups
add_row(NO_ALLOC, NO_LANE, NO_LANE, NO_LANE, 1, 32'h0, 0, 0, NO_RET);
add_row(NO_ALLOC, NO_LANE, NO_LANE, NO_LANE, 1, 32'h0, 0, 0, NO_RET);
add_row(NO_ALLOC, NO_LANE, NO_LANE, NO_LANE, 1, 32'h0, 0, 0, NO_RET);
add_row(NO_ALLOC, NO_LANE, NO_LANE, NO_LANE, 1, 32'h0, 0, 0, NO_RET);

// Three branches resolved together, lanes in reverse order
add_row(new_branch(32'h100, 0), NO_LANE, NO_LANE, NO_LANE, 0, 32'h100, 0, 0, NO_RET);
add_row(new_branch(32'h104, 1), NO_LANE, NO_LANE, NO_LANE, 0, 32'h104, 0, 1, NO_RET);
add_row(new_branch(32'h108, 0), NO_LANE, NO_LANE, NO_LANE, 0, 32'h108, 0, 2, NO_RET);
add_row(NO_ALLOC, resolve(2, 0, 0, 32'h10c), resolve(1, 0, 1, 32'h180),
        resolve(0, 0, 0, 32'h104), 0, 32'h0, 0, 3, NO_RET);
add_row(NO_ALLOC, NO_LANE, NO_LANE, NO_LANE, 0, 32'h0, 0, 3, NO_RET);
add_row(NO_ALLOC, NO_LANE, NO_LANE, NO_LANE, 0, 32'h0, 0, 3, retired(0, 0, 32'h100, 32'h104));
add_row(NO_ALLOC, NO_LANE, NO_LANE, NO_LANE, 0, 32'h0, 0, 3, retired(0, 1, 32'h104, 32'h180));
add_row(NO_ALLOC, NO_LANE, NO_LANE, NO_LANE, 0, 32'h0, 0, 3, retired(0, 0, 32'h108, 32'h10c));
add_row(NO_ALLOC, NO_LANE, NO_LANE, NO_LANE, 0, 32'h0, 0, 3, NO_RET);

// Youngest resolves first, oldest last
add_row(new_branch(32'h200, 0), NO_LANE, NO_LANE, NO_LANE, 0, 32'h200, 0, 3, NO_RET);
add_row(new_branch(32'h204, 0), NO_LANE, NO_LANE, NO_LANE, 0, 32'h204, 0, 4, NO_RET);
add_row(new_branch(32'h208, 0), NO_LANE, NO_LANE, NO_LANE, 0, 32'h208, 0, 5, NO_RET);
add_row(NO_ALLOC, resolve(5, 0, 1, 32'h280), NO_LANE, NO_LANE, 0, 32'h0, 0, 6, NO_RET);
add_row(NO_ALLOC, NO_LANE, resolve(4, 0, 0, 32'h208), NO_LANE, 0, 32'h0, 0, 6, NO_RET);
add_row(NO_ALLOC, NO_LANE, NO_LANE, NO_LANE, 0, 32'h0, 0, 6, NO_RET);
add_row(NO_ALLOC, NO_LANE, NO_LANE, resolve(3, 0, 1, 32'h240), 0, 32'h0, 0, 6, NO_RET);
add_row(NO_ALLOC, NO_LANE, NO_LANE, NO_LANE, 0, 32'h0, 0, 6, NO_RET);
add_row(NO_ALLOC, NO_LANE, NO_LANE, NO_LANE, 0, 32'h0, 0, 6, retired(0, 1, 32'h200, 32'h240));
add_row(NO_ALLOC, NO_LANE, NO_LANE, NO_LANE, 0, 32'h0, 0, 6, retired(0, 0, 32'h204, 32'h208));
add_row(NO_ALLOC, NO_LANE, NO_LANE, NO_LANE, 0, 32'h0, 0, 6, retired(0, 1, 32'h208, 32'h280));

// Oldest mispredicts behind resolved younger entries
add_row(new_branch(32'h300, 1), NO_LANE, NO_LANE, NO_LANE, 0, 32'h300, 0, 6, NO_RET);
add_row(new_branch(32'h304, 0), NO_LANE, NO_LANE, NO_LANE, 0, 32'h304, 0, 7, NO_RET);
add_row(new_branch(32'h308, 0), NO_LANE, NO_LANE, NO_LANE, 0, 32'h308, 0, 0, NO_RET);
add_row(NO_ALLOC, resolve(7, 0, 0, 32'h308), resolve(0, 0, 1, 32'h380), NO_LANE,
        0, 32'h0, 0, 1, NO_RET);
add_row(NO_ALLOC, NO_LANE, NO_LANE, resolve(6, 1, 0, 32'h400), 0, 32'h0, 0, 1, NO_RET);
add_row(NO_ALLOC, NO_LANE, NO_LANE, NO_LANE, 0, 32'h0, 0, 1, NO_RET);
add_row(NO_ALLOC, NO_LANE, NO_LANE, NO_LANE, 0, 32'h0, 0, 0, retired(1, 0, 32'h300, 32'h400));
add_row(NO_ALLOC, NO_LANE, NO_LANE, NO_LANE, 0, 32'h0, 0, 0, NO_RET);
add_row(NO_ALLOC, NO_LANE, NO_LANE, NO_LANE, 0, 32'h0, 0, 0, NO_RET);

// Same pc released taken twice under equal history
add_row(new_branch(32'h500, 0), NO_LANE, NO_LANE, NO_LANE, 0, 32'h500, 0, 0, NO_RET);
add_row(new_branch(32'h500, 0), NO_LANE, NO_LANE, NO_LANE, 0, 32'h500, 0, 1, NO_RET);
add_row(NO_ALLOC, resolve(0, 0, 1, 32'h540), resolve(1, 0, 1, 32'h540), NO_LANE,
        0, 32'h500, 0, 2, NO_RET);
add_row(NO_ALLOC, NO_LANE, NO_LANE, NO_LANE, 0, 32'h500, 0, 2, NO_RET);
add_row(NO_ALLOC, NO_LANE, NO_LANE, NO_LANE, 0, 32'h500, 0, 2, retired(0, 1, 32'h500, 32'h540));
add_row(NO_ALLOC, NO_LANE, NO_LANE, NO_LANE, 0, 32'h500, 0, 2, retired(0, 1, 32'h500, 32'h540));
add_row(NO_ALLOC, NO_LANE, NO_LANE, NO_LANE, 0, 32'h500, 0, 2, NO_RET);
add_row(NO_ALLOC, NO_LANE, NO_LANE, NO_LANE, 0, 32'h500, 0, 2, NO_RET);

// Fill the table, then release the head
add_row(new_branch(32'h600, 0), NO_LANE, NO_LANE, NO_LANE, 0, 32'h600, 0, 2, NO_RET);
add_row(new_branch(32'h604, 0), NO_LANE, NO_LANE, NO_LANE, 0, 32'h604, 0, 3, NO_RET);
add_row(new_branch(32'h608, 0), NO_LANE, NO_LANE, NO_LANE, 0, 32'h608, 0, 4, NO_RET);
add_row(new_branch(32'h60c, 0), NO_LANE, NO_LANE, NO_LANE, 0, 32'h60c, 0, 5, NO_RET);
add_row(new_branch(32'h610, 0), NO_LANE, NO_LANE, NO_LANE, 0, 32'h610, 0, 6, NO_RET);
add_row(new_branch(32'h614, 0), NO_LANE, NO_LANE, NO_LANE, 0, 32'h614, 0, 7, NO_RET);
add_row(new_branch(32'h618, 0), NO_LANE, NO_LANE, NO_LANE, 0, 32'h618, 0, 0, NO_RET);
add_row(new_branch(32'h61c, 0), NO_LANE, NO_LANE, NO_LANE, 0, 32'h61c, 0, 1, NO_RET);
add_row(NO_ALLOC, resolve(2, 0, 0, 32'h604), NO_LANE, NO_LANE, 0, 32'h0, 1, 2, NO_RET);
add_row(NO_ALLOC, NO_LANE, NO_LANE, NO_LANE, 0, 32'h0, 1, 2, NO_RET);
add_row(NO_ALLOC, NO_LANE, NO_LANE, NO_LANE, 0, 32'h0, 0, 2, retired(0, 0, 32'h600, 32'h604));
add_row(NO_ALLOC, NO_LANE, NO_LANE, NO_LANE, 0, 32'h0, 0, 2, NO_RET);

// ==== tests/branch_resolution_tb.sv ====
`timescale 1ns/1ns

module branch_resolution_tb;

    typedef struct packed {
        brat_pkg::alloc_req_t                             alloc;
        brat_pkg::exec_result_t [brat_pkg::NUM_LANES-1:0] lanes;
        logic                                             rnd;
        brat_pkg::pc_t                                    lookup;
        logic                                             full;
        brat_pkg::brat_id_t                               id;
        brat_pkg::retire_t                                ret;
    } vec_t;

    localparam brat_pkg::alloc_req_t   NO_ALLOC = '0;
    localparam brat_pkg::exec_result_t NO_LANE  = '0;
    localparam brat_pkg::retire_t      NO_RET   = '0;

    logic                                             clk;
    logic                                             reset_i;
    brat_pkg::alloc_req_t                             alloc;
    brat_pkg::brat_id_t                               alloc_id;
    logic                                             brat_full;
    brat_pkg::pc_t                                    predict_pc;
    logic                                             predict_taken;
    brat_pkg::exec_result_t [brat_pkg::NUM_LANES-1:0] exec;
    brat_pkg::retire_t                                retire;
    logic                                             redirect;
    brat_pkg::pc_t                                    redirect_pc;

    vec_t vecs[$];
    int   seed = 26;
    int   cycles;
    int   limit;

    // Reference model of the predictor and of the stored branch state
    brat_pkg::ghist_t m_hist;
    logic [1:0]       m_pht [brat_pkg::PHT_ENTRIES];
    brat_pkg::pc_t    m_pc_q[$];
    brat_pkg::ghist_t m_hist_q[$];

    branch_resolution_top i_dut (
        .clk             (clk),
        .reset_i         (reset_i),
        .alloc_i         (alloc),
        .alloc_id_o      (alloc_id),
        .brat_full_o     (brat_full),
        .predict_pc_i    (predict_pc),
        .predict_taken_o (predict_taken),
        .exec_i          (exec),
        .retire_o        (retire),
        .redirect_o      (redirect),
        .redirect_pc_o   (redirect_pc)
    );

    // ========================================
    // Row builders
    // ========================================

    function automatic brat_pkg::alloc_req_t new_branch(brat_pkg::pc_t pc, logic pt);
        return '{valid: 1'b1, pc: pc, predicted_taken: pt};
    endfunction

    function automatic brat_pkg::exec_result_t resolve(brat_pkg::brat_id_t id, logic m,
                                                       logic t, brat_pkg::pc_t cpc);
        return '{valid: 1'b1, id: id, mispredicted: m, taken: t, correct_pc: cpc};
    endfunction

    function automatic brat_pkg::retire_t retired(logic m, logic t, brat_pkg::pc_t pc,
                                                  brat_pkg::pc_t cpc);
        return '{valid: 1'b1, mispredicted: m, taken: t, pc: pc, correct_pc: cpc,
                 history: '0};
    endfunction

    task automatic add_row(brat_pkg::alloc_req_t a, brat_pkg::exec_result_t l0,
                           brat_pkg::exec_result_t l1, brat_pkg::exec_result_t l2,
                           logic rnd, brat_pkg::pc_t lookup, logic full,
                           brat_pkg::brat_id_t id, brat_pkg::retire_t r);
        vec_t v;
        v.alloc  = a;
        v.lanes  = {l2, l1, l0};
        v.rnd    = rnd;
        v.lookup = lookup;
        v.full   = full;
        v.id     = id;
        v.ret    = r;
        vecs.push_back(v);
    endtask

    task automatic load_vectors();
        `include "tb_vectors.svh"
    endtask

    task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
        $display("MISMATCH at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
        $display("Finished with errors");
        $fatal(1, "stopping at first error");
    endtask

    // ========================================
    // Clock and timeout
    // ========================================

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (limit > 0 && cycles > limit) begin
                $display("Timeout: the run did not end within %0d cycles", limit);
                $display("Finished with errors");
                $fatal(1, "timeout");
            end
        end
    end

    // ========================================
    // Stimulus and checks
    // ========================================

    initial begin
        logic [brat_pkg::PHT_INDEX_W-1:0] idx;
        vec_t          v;
        logic          exp_redir;
        brat_pkg::pc_t exp_ret_pc;
        reset_i    = 1'b1;
        alloc      = NO_ALLOC;
        exec       = '0;
        predict_pc = '0;
        limit      = 0;
        m_hist     = '0;
        for (int i = 0; i < brat_pkg::PHT_ENTRIES; i++) begin
            m_pht[i] = 2'b01;
        end
        load_vectors();
        limit = vecs.size() + 16 + 20;
        repeat (16) @(posedge clk);
        #1 reset_i = 1'b0;

        foreach (vecs[r]) begin
            v = vecs[r];
            @(posedge clk);
            #1;
            alloc      = v.alloc;
            exec       = v.lanes;
            predict_pc = v.rnd ? brat_pkg::pc_t'($random(seed)) : v.lookup;
            @(negedge clk);

            idx = predict_pc[7:2] ^ m_hist;
            assert (predict_taken == m_pht[idx][1])
                else report_mismatch("predict_taken_o", predict_taken, m_pht[idx][1]);
            assert (brat_full == v.full)
                else report_mismatch("brat_full_o", brat_full, v.full);
            assert (alloc_id == v.id)
                else report_mismatch("alloc_id_o", alloc_id, v.id);
            assert (retire.valid == v.ret.valid)
                else report_mismatch("retire_o.valid", retire.valid, v.ret.valid);
            exp_redir = v.ret.valid && v.ret.mispredicted;
            assert (redirect == exp_redir)
                else report_mismatch("redirect_o", redirect, exp_redir);

            if (v.ret.valid) begin
                assert (retire.pc == v.ret.pc)
                    else report_mismatch("retire_o.pc", retire.pc, v.ret.pc);
                assert (retire.taken == v.ret.taken)
                    else report_mismatch("retire_o.taken", retire.taken, v.ret.taken);
                assert (retire.mispredicted == v.ret.mispredicted)
                    else report_mismatch("retire_o.mispredicted", retire.mispredicted,
                                         v.ret.mispredicted);
                assert (retire.correct_pc == v.ret.correct_pc)
                    else report_mismatch("retire_o.correct_pc", retire.correct_pc,
                                         v.ret.correct_pc);
                assert (retire.history == m_hist_q[0])
                    else report_mismatch("retire_o.history", retire.history, m_hist_q[0]);
                if (exp_redir) begin
                    assert (redirect_pc == v.ret.correct_pc)
                        else report_mismatch("redirect_pc_o", redirect_pc, v.ret.correct_pc);
                end

                // Counter moves one step toward the real outcome
                idx = m_pc_q[0][7:2] ^ m_hist_q[0];
                if (v.ret.taken && m_pht[idx] != 2'b11) begin
                    m_pht[idx] = m_pht[idx] + 2'd1;
                end else if (!v.ret.taken && m_pht[idx] != 2'b00) begin
                    m_pht[idx] = m_pht[idx] - 2'd1;
                end
                exp_ret_pc = m_pc_q[0];
                assert (exp_ret_pc == v.ret.pc)
                    else report_mismatch("model pc", exp_ret_pc, v.ret.pc);
                if (v.ret.mispredicted) begin
                    m_hist = {m_hist_q[0][brat_pkg::HIST_W-2:0], v.ret.taken};
                    m_pc_q.delete();
                    m_hist_q.delete();
                end else begin
                    void'(m_pc_q.pop_front());
                    void'(m_hist_q.pop_front());
                end
            end

            // Allocation stores the history seen before its own shift
            if (v.alloc.valid) begin
                m_pc_q.push_back(v.alloc.pc);
                m_hist_q.push_back(m_hist);
                if (v.alloc.predicted_taken && !exp_redir) begin
                    m_hist = {m_hist[brat_pkg::HIST_W-2:0], 1'b1};
                end
            end
        end

        @(posedge clk);
        #1;
        alloc = NO_ALLOC;
        exec  = '0;
        $display("Finished with no errors");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+tests
common/brat_pkg.sv
brat/brat_table.sv
logic/gshare_predictor.sv
logic/branch_resolution_top.sv
tests/branch_resolution_tb.sv

// ==== Bender.yml ====
package:
  name: branch_resolution

sources:
  - files:
      - common/brat_pkg.sv
      - brat/brat_table.sv
      - logic/gshare_predictor.sv
      - logic/branch_resolution_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/branch_resolution_tb.sv
